// ==== rtl/lb_pkg.sv ====
package lb_pkg;

   // Local bus widths
   localparam int LB_ADDR_W = 24;
   localparam int LB_DATA_W = 32;

   // Trace buffer geometry, 2048 words of 32 bits
   localparam int TRACE_AW = 11;
   localparam int TRACE_DW = 32;

   // Low trace bits watched by the trigger
   localparam int TRIG_W = 9;

   // Register indices in the low address byte
   localparam logic [7:0] REG_POWER = 8'h76;
   localparam logic [7:0] REG_TRACE = 8'h78;
   localparam logic [7:0] REG_LINK  = 8'h79;
   localparam logic [7:0] REG_THRU  = 8'h7a;

   // ASCII read-back words
   localparam logic [31:0] STR_GOOD = "Good";
   localparam logic [31:0] STR_BYE  = "bye ";
   localparam logic [31:0] STR_WORL = "Worl";
   localparam logic [31:0] STR_DAVI = "Davi";
   // Ends with CR LF
   localparam logic [31:0] STR_END  = {"d!", 16'h0d0a};

   // One bus address, decoded as a register write or as a read selection
   typedef union packed {
      struct packed {
         logic [15:0] upper;
         logic [7:0]  reg_index;
      } regs;
      struct packed {
         logic [10:0] upper;
         logic        trace_page;
         logic        spare;
         logic [10:0] ram_addr;
      } rd;
   } lb_addr_u;

endpackage

// ==== rtl/lb_ctrl_regs.sv ====
`timescale 1ns/1ps

module lb_ctrl_regs (
   input  logic                         fp_clk,
   input  logic                         rst_n,
   input  lb_pkg::lb_addr_u             lb_addr,
   input  logic                         lb_strobe,
   input  logic                         lb_rd,
   input  logic [lb_pkg::LB_DATA_W-1:0] lb_wdata,
   output logic [3:0]                   power_conf,
   output logic                         an_bypass,
   output logic                         rd_hack,
   output logic                         nomangle,
   output logic                         trace_nowait,
   output logic                         trace_arm
);

   logic       wr_stb;
   logic [7:0] idx;

   // A write is any strobe without the read flag
   assign wr_stb = lb_strobe & ~lb_rd;
   assign idx    = lb_addr.regs.reg_index;

   always_ff @(posedge fp_clk) begin
      if (!rst_n) begin
         power_conf   <= 4'b0000;
         an_bypass    <= 1'b1;
         rd_hack      <= 1'b0;
         nomangle     <= 1'b0;
         trace_nowait <= 1'b0;
         trace_arm    <= 1'b0;
      end else begin
         // Single-cycle arm, one edge after the strobe
         trace_arm <= wr_stb && (idx == lb_pkg::REG_TRACE);

         if (wr_stb) begin
            case (idx)
               lb_pkg::REG_POWER: begin
                  power_conf <= lb_wdata[3:0];
               end
               lb_pkg::REG_TRACE: begin
                  trace_nowait <= lb_wdata[0];
               end
               lb_pkg::REG_LINK: begin
                  // Bit 1 disparity hack, bit 0 autonegotiation bypass
                  rd_hack   <= lb_wdata[1];
                  an_bypass <= lb_wdata[0];
               end
               lb_pkg::REG_THRU: begin
                  nomangle <= lb_wdata[0];
               end
               default: begin
                  // Unmapped index, nothing to update
               end
            endcase
         end
      end
   end

endmodule

// ==== rtl/trace_capture.sv ====
`timescale 1ns/1ps

module trace_capture (
   input  logic                         fp_clk,
   input  logic                         rst_n,
   input  logic [lb_pkg::TRACE_DW-1:0]  trace_in,
   input  logic                         trace_arm,
   input  logic                         trace_nowait,
   output logic                         trace_req,
   output logic [lb_pkg::TRACE_AW-1:0]  wr_addr,
   output logic [lb_pkg::TRACE_DW-1:0]  wr_data,
   output logic                         wr_en
);

   logic [lb_pkg::TRACE_DW-1:0] hist1;
   logic [lb_pkg::TRACE_DW-1:0] hist2;
   logic                        run;
   logic                        trace_done;
   logic                        trig;
   logic                        start;
   logic                        ending;

   // Trigger on any change of the low bits over two cycles
   assign trig = hist2[lb_pkg::TRIG_W-1:0] != trace_in[lb_pkg::TRIG_W-1:0];

   // No restart while the done flag is still waiting for req to drop
   assign start = trace_req & ~run & ~trace_done & (trace_nowait | trig);

   assign ending = run & (wr_addr == '1);

   // Recording the delayed word keeps the samples ahead of the trigger
   assign wr_data = hist2;
   assign wr_en   = run;

   // Input history
   always_ff @(posedge fp_clk) begin
      hist1 <= trace_in;
      hist2 <= hist1;
   end

   // Write address and run flag
   always_ff @(posedge fp_clk) begin
      if (!rst_n) begin
         run     <= 1'b0;
         wr_addr <= '0;
      end else begin
         wr_addr <= run ? wr_addr + 1'b1 : '0;
         if (start) begin
            run <= 1'b1;
         end
         if (ending) begin
            run <= 1'b0;
         end
      end
   end

   // Request/done flag pair
   always_ff @(posedge fp_clk) begin
      if (!rst_n) begin
         trace_req  <= 1'b0;
         trace_done <= 1'b0;
      end else begin
         if (trace_arm) begin
            trace_req <= 1'b1;
         end
         // Done wins over a late arm
         if (trace_done) begin
            trace_req <= 1'b0;
         end

         if (ending) begin
            trace_done <= 1'b1;
         end
         if (!trace_req) begin
            trace_done <= 1'b0;
         end
      end
   end

endmodule

// ==== rtl/trace_ram.sv ====
`timescale 1ns/1ps

module trace_ram (
   input  logic                         fp_clk,
   input  logic [lb_pkg::TRACE_AW-1:0]  wr_addr,
   input  logic [lb_pkg::TRACE_DW-1:0]  wr_data,
   input  logic                         wr_en,
   input  logic [lb_pkg::TRACE_AW-1:0]  rd_addr,
   output logic [lb_pkg::TRACE_DW-1:0]  rd_data
);

   localparam int DEPTH = 1 << lb_pkg::TRACE_AW;

   logic [lb_pkg::TRACE_DW-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge fp_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Registered read port, old data on a same-address collision
   always_ff @(posedge fp_clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== rtl/lb_read_mux.sv ====
`timescale 1ns/1ps

module lb_read_mux (
   input  logic                         fp_clk,
   input  logic                         rst_n,
   input  lb_pkg::lb_addr_u             lb_addr,
   input  logic                         trace_req,
   input  logic [lb_pkg::TRACE_DW-1:0]  rd_data,
   output logic [lb_pkg::TRACE_AW-1:0]  rd_addr,
   output logic [lb_pkg::LB_DATA_W-1:0] lb_rdata
);

   logic [1:0] word_sel;

   // The RAM sees the address straight from the bus
   assign rd_addr  = lb_addr.rd.ram_addr;
   assign word_sel = lb_addr.rd.ram_addr[1:0];

   // Follows the address on every cycle, no strobe involved
   always_ff @(posedge fp_clk) begin
      if (!rst_n) begin
         lb_rdata <= '0;
      end else if (lb_addr.rd.trace_page) begin
         // Second stage behind the RAM read register
         lb_rdata <= rd_data;
      end else begin
         case (word_sel)
            2'd0: lb_rdata <= lb_pkg::STR_GOOD;
            2'd1: lb_rdata <= lb_pkg::STR_BYE;
            // Davi while a trace request is outstanding
            2'd2: lb_rdata <= trace_req ? lb_pkg::STR_DAVI : lb_pkg::STR_WORL;
            default: lb_rdata <= lb_pkg::STR_END;
         endcase
      end
   end

endmodule

// ==== rtl/lb_trace_top.sv ====
`timescale 1ns/1ps

module lb_trace_top (
   input  logic                         fp_clk,
   input  logic                         rst_n,
   input  logic [lb_pkg::LB_ADDR_W-1:0] lb_addr,
   input  logic                         lb_strobe,
   input  logic                         lb_rd,
   input  logic [lb_pkg::LB_DATA_W-1:0] lb_wdata,
   input  logic [lb_pkg::TRACE_DW-1:0]  trace_in,
   output logic [lb_pkg::LB_DATA_W-1:0] lb_rdata,
   output logic [3:0]                   power_conf,
   output logic                         an_bypass,
   output logic                         rd_hack,
   output logic                         nomangle
);

   // Register block to recorder
   logic                        trace_arm;
   logic                        trace_nowait;

   // Recorder status back to the read mux
   logic                        trace_req;

   // Trace buffer ports
   logic [lb_pkg::TRACE_AW-1:0] wr_addr;
   logic [lb_pkg::TRACE_DW-1:0] wr_data;
   logic                        wr_en;
   logic [lb_pkg::TRACE_AW-1:0] rd_addr;
   logic [lb_pkg::TRACE_DW-1:0] rd_data;

   lb_ctrl_regs u_regs (
      .fp_clk       (fp_clk),
      .rst_n        (rst_n),
      .lb_addr      (lb_addr),
      .lb_strobe    (lb_strobe),
      .lb_rd        (lb_rd),
      .lb_wdata     (lb_wdata),
      .power_conf   (power_conf),
      .an_bypass    (an_bypass),
      .rd_hack      (rd_hack),
      .nomangle     (nomangle),
      .trace_nowait (trace_nowait),
      .trace_arm    (trace_arm)
   );

   trace_capture u_capture (
      .fp_clk       (fp_clk),
      .rst_n        (rst_n),
      .trace_in     (trace_in),
      .trace_arm    (trace_arm),
      .trace_nowait (trace_nowait),
      .trace_req    (trace_req),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .wr_en        (wr_en)
   );

   trace_ram u_ram (
      .fp_clk  (fp_clk),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   lb_read_mux u_read_mux (
      .fp_clk    (fp_clk),
      .rst_n     (rst_n),
      .lb_addr   (lb_addr),
      .trace_req (trace_req),
      .rd_data   (rd_data),
      .rd_addr   (rd_addr),
      .lb_rdata  (lb_rdata)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic fp_clk,
   output logic rst_n
);

   localparam int HALF_NS     = 20;
   localparam int RST_CYCLES  = 4;

   initial begin
      fp_clk = 1'b0;
      forever #HALF_NS fp_clk = ~fp_clk;
   end

   // Reset released on the edge that ends the fourth cycle
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge fp_clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== tests/tb_lb_trace.sv ====
`timescale 1ns/1ps

module tb_lb_trace;

   localparam int     CLK_NS      = 40;
   localparam int     DEPTH       = 2048;
   localparam int     ACCESSES    = 40;
   localparam int     CAPTURES    = 4;
   localparam longint WATCHDOG_NS = 2 * (ACCESSES + CAPTURES * DEPTH) * CLK_NS;
   localparam int     POLL_LIMIT  = 2 * DEPTH + 64;

   // Read-back words as the bus should return them
   localparam logic [31:0] WORD_GOOD = "Good";
   localparam logic [31:0] WORD_BYE  = "bye ";
   localparam logic [31:0] WORD_WORL = "Worl";
   localparam logic [31:0] WORD_DAVI = "Davi";
   localparam logic [31:0] WORD_END  = {"d!", 8'h0d, 8'h0a};

   logic        fp_clk;
   logic        rst_n;
   logic [23:0] lb_addr;
   logic        lb_strobe;
   logic        lb_rd;
   logic [31:0] lb_wdata;
   logic [31:0] trace_in;
   logic [31:0] lb_rdata;
   logic [3:0]  power_conf;
   logic        an_bypass;
   logic        rd_hack;
   logic        nomangle;

   // Reference model of the control registers
   logic [3:0]  exp_power;
   logic        exp_an_bypass;
   logic        exp_rd_hack;
   logic        exp_nomangle;

   logic [31:0] lfsr;
   logic [31:0] trace_log [$];
   logic [31:0] rd_words [DEPTH];
   logic        hold_low;
   logic [8:0]  held_bits;
   int          mismatches;
   int          failures;

   tb_clock clkgen (
      .fp_clk (fp_clk),
      .rst_n  (rst_n)
   );

   lb_trace_top UUT (
      .fp_clk     (fp_clk),
      .rst_n      (rst_n),
      .lb_addr    (lb_addr),
      .lb_strobe  (lb_strobe),
      .lb_rd      (lb_rd),
      .lb_wdata   (lb_wdata),
      .trace_in   (trace_in),
      .lb_rdata   (lb_rdata),
      .power_conf (power_conf),
      .an_bypass  (an_bypass),
      .rd_hack    (rd_hack),
      .nomangle   (nomangle)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Every clock gets a fresh trace word, and the model logs it
   task automatic next_cycle();
      logic [31:0] w;
      @(posedge fp_clk);
      w = rand_bits(32);
      if (hold_low) begin
         w[8:0] = held_bits;
      end
      trace_in <= w;
      trace_log.push_back(w);
   endtask

   function automatic void model_write(input logic [7:0] idx, input logic [31:0] data);
      case (idx)
         lb_pkg::REG_POWER: exp_power = data[3:0];
         lb_pkg::REG_LINK: begin
            exp_rd_hack   = data[1];
            exp_an_bypass = data[0];
         end
         lb_pkg::REG_THRU: exp_nomangle = data[0];
         default: begin
         end
      endcase
   endfunction

   task automatic write_reg(input logic [7:0] idx, input logic [31:0] data);
      logic [31:0] r;
      next_cycle();
      r = rand_bits(16);
      lb_addr   <= {r[15:0], idx};
      lb_wdata  <= data;
      lb_rd     <= 1'b0;
      lb_strobe <= 1'b1;
      next_cycle();
      lb_strobe <= 1'b0;
      lb_rd     <= 1'b1;
      model_write(idx, data);
   endtask

   // Upper bits and spare are random, they must not matter
   task automatic drive_read_addr(input logic page, input logic [10:0] ram_addr);
      logic [31:0] r;
      next_cycle();
      r = rand_bits(12);
      lb_addr <= {r[11:1], page, r[0], ram_addr};
      lb_rd   <= 1'b1;
   endtask

   function automatic void check_regs();
      if (power_conf !== exp_power) begin
         $display("MISMATCH at %0t: power_conf expected %h got %h", $time, exp_power, power_conf);
         mismatches++;
      end
      if (an_bypass !== exp_an_bypass) begin
         $display("MISMATCH at %0t: an_bypass expected %b got %b", $time, exp_an_bypass,
                  an_bypass);
         mismatches++;
      end
      if (rd_hack !== exp_rd_hack) begin
         $display("MISMATCH at %0t: rd_hack expected %b got %b", $time, exp_rd_hack, rd_hack);
         mismatches++;
      end
      if (nomangle !== exp_nomangle) begin
         $display("MISMATCH at %0t: nomangle expected %b got %b", $time, exp_nomangle, nomangle);
         mismatches++;
      end
   endfunction

   // Selection 2 reads Davi until the request drops
   task automatic wait_capture_end(input int min_cycles);
      int   n;
      logic done;
      n    = 0;
      done = 1'b0;
      while (!done && n < POLL_LIMIT) begin
         next_cycle();
         @(negedge fp_clk);
         if (lb_rdata === WORD_WORL) begin
            done = 1'b1;
         end else begin
            if (lb_rdata !== WORD_DAVI) begin
               $display("MISMATCH at %0t: lb_rdata expected %h got %h", $time, WORD_DAVI,
                        lb_rdata);
               mismatches++;
            end
            n++;
         end
      end
      if (!done) begin
         $display("Capture never ended, selection 2 did not return to Worl");
         failures++;
      end else if (n < min_cycles) begin
         $display("Capture ended after %0d cycles, too soon to fill the buffer", n);
         failures++;
      end
   endtask

   // One address per cycle, data shows two cycles later
   task automatic read_buffer();
      for (int k = 0; k < DEPTH + 2; k++) begin
         drive_read_addr(1'b1, (k < DEPTH) ? 11'(k) : 11'(DEPTH - 1));
         @(negedge fp_clk);
         if (k >= 2) begin
            rd_words[k-2] = lb_rdata;
         end
      end
   endtask

   task automatic check_against_log();
      int base;
      base = -1;
      for (int i = 0; i < trace_log.size(); i++) begin
         if (base < 0 && trace_log[i] === rd_words[0]) begin
            base = i;
         end
      end
      if (base < 0 || base + DEPTH > trace_log.size()) begin
         $display("Trace word at address 0 (%h) not found in the driven sequence", rd_words[0]);
         failures++;
      end else begin
         for (int j = 0; j < DEPTH; j++) begin
            if (rd_words[j] !== trace_log[base+j]) begin
               $display("MISMATCH at %0t: trace word %0d expected %h got %h", $time, j,
                        trace_log[base+j], rd_words[j]);
               mismatches++;
            end
         end
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [7:0]  idx;
      logic [1:0]  sel;
      logic [31:0] expected;
      logic [8:0]  old_bits;
      logic [8:0]  new_bits;

      lfsr          = 32'h717a;
      lb_addr       = '0;
      lb_strobe     = 1'b0;
      lb_rd         = 1'b1;
      lb_wdata      = '0;
      trace_in      = '0;
      hold_low      = 1'b0;
      held_bits     = '0;
      mismatches    = 0;
      failures      = 0;
      exp_power     = 4'h0;
      exp_an_bypass = 1'b1;
      exp_rd_hack   = 1'b0;
      exp_nomangle  = 1'b0;

      wait (rst_n === 1'b1);
      @(negedge fp_clk);
      check_regs();
      if (lb_rdata !== 32'h0) begin
         $display("MISMATCH at %0t: lb_rdata expected %h got %h", $time, 32'h0, lb_rdata);
         mismatches++;
      end

      // Random writes, mapped and unmapped indices
      for (int i = 0; i < 24; i++) begin
         r = rand_bits(2);
         case (r[1:0])
            2'd0: idx = lb_pkg::REG_POWER;
            2'd1: idx = lb_pkg::REG_LINK;
            2'd2: idx = lb_pkg::REG_THRU;
            default: begin
               r   = rand_bits(8);
               idx = r[7:0];
               if (idx >= 8'h76 && idx <= 8'h7a) begin
                  idx = 8'h3c;
               end
            end
         endcase
         write_reg(idx, rand_bits(32));
         @(negedge fp_clk);
         check_regs();
      end

      // String words, each address held three cycles
      for (int i = 0; i < 12; i++) begin
         case (i % 3)
            0: begin
               sel      = 2'd0;
               expected = WORD_GOOD;
            end
            1: begin
               sel      = 2'd1;
               expected = WORD_BYE;
            end
            default: begin
               sel      = 2'd3;
               expected = WORD_END;
            end
         endcase
         r = rand_bits(21);
         next_cycle();
         lb_addr   <= {r[20:10], 1'b0, r[9], r[8:0], sel};
         lb_strobe <= 1'b1;
         lb_rd     <= 1'b1;
         next_cycle();
         lb_strobe <= 1'b0;
         next_cycle();
         @(negedge fp_clk);
         if (lb_rdata !== expected) begin
            $display("MISMATCH at %0t: lb_rdata expected %h got %h", $time, expected, lb_rdata);
            mismatches++;
         end
      end

      // Immediate capture, then the whole buffer against the log
      trace_log.delete();
      write_reg(lb_pkg::REG_TRACE, 32'h1);
      r = rand_bits(9);
      drive_read_addr(1'b0, {r[8:0], 2'd2});
      wait_capture_end(DEPTH);
      read_buffer();
      check_against_log();

      // Triggered capture on a change of the low bits
      r         = rand_bits(9);
      old_bits  = r[8:0];
      held_bits = old_bits;
      hold_low  = 1'b1;
      repeat (4) next_cycle();
      trace_log.delete();
      write_reg(lb_pkg::REG_TRACE, 32'h0);
      r = rand_bits(9);
      drive_read_addr(1'b0, {r[8:0], 2'd2});
      for (int i = 0; i < 100; i++) begin
         next_cycle();
         @(negedge fp_clk);
         if (lb_rdata !== WORD_DAVI) begin
            $display("MISMATCH at %0t: lb_rdata expected %h got %h", $time, WORD_DAVI, lb_rdata);
            mismatches++;
         end
      end
      r        = rand_bits(9);
      new_bits = r[8:0];
      if (new_bits == old_bits) begin
         new_bits = ~old_bits;
      end
      held_bits = new_bits;
      wait_capture_end(DEPTH);
      hold_low = 1'b0;
      read_buffer();
      check_against_log();
      if (rd_words[0][8:0] !== old_bits) begin
         $display("MISMATCH at %0t: trace word 0 low bits expected %h got %h", $time, old_bits,
                  rd_words[0][8:0]);
         mismatches++;
      end
      if (rd_words[1][8:0] !== new_bits && rd_words[2][8:0] !== new_bits) begin
         $display("Trigger change is not within the first three trace entries");
         failures++;
      end

      $display("%0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Budget of 40 accesses and 4 full captures, doubled
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
      $display("%0d mismatches, %0d other errors", mismatches, failures);
      $display("test failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
rtl/lb_pkg.sv
rtl/lb_ctrl_regs.sv
rtl/trace_capture.sv
rtl/trace_ram.sv
rtl/lb_read_mux.sv
rtl/lb_trace_top.sv
tests/tb_clock.sv
tests/tb_lb_trace.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_lb_trace
FILELIST  = filelist.f
OBJDIR    = obj_dir

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Pass only if the simulation printed the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^test passed$$'

clean:
	rm -rf $(OBJDIR)
